/* src/hazard_defs.svh */
// hazard unit constants for scoreboard depth, field widths and the dual-allocation threshold
`ifndef HAZARD_DEFS_SVH
`define HAZARD_DEFS_SVH

// number of in-flight write slots
`define SB_DEPTH 8

// commit ID indexes one slot
`define SB_ID_W 3

// architectural register number, x0..x31
`define REG_ADDR_W 5

// execution unit type code
`define EXU_TYPE_W 3

// two free slots left as long as no more than this many are used
`define SB_MAX_USED_FOR_TWO 6

`endif

/* src/sb_pkg.sv */
// scoreboard types for register numbers, commit IDs, per-slot vectors and occupancy count
`default_nettype none

`include "hazard_defs.svh"

package sb_pkg;

    // destination or source register number
    typedef logic [`REG_ADDR_W-1:0] reg_addr_t;

    // slot index handed out at issue and returned at commit
    typedef logic [`SB_ID_W-1:0] commit_id_t;

    // one bit per scoreboard slot
    typedef logic [`SB_DEPTH-1:0] slot_vec_t;

    // 0..8 occupied slots needs one bit more than an ID
    typedef logic [`SB_ID_W:0] used_count_t;

endpackage

`default_nettype wire

/* src/issue_pkg.sv */
// instruction-side types for execution unit codes and the two-bit issue grant
`default_nettype none

`include "hazard_defs.svh"

package issue_pkg;

    typedef logic [`EXU_TYPE_W-1:0] exu_type_t;
    typedef logic [1:0] issue_vec_t;    // bit0 inst1, bit1 inst2

    // unit codes as produced by decode
    localparam exu_type_t EXU_ALU = 3'd0;
    localparam exu_type_t EXU_MUL = 3'd1;
    localparam exu_type_t EXU_DIV = 3'd2;
    localparam exu_type_t EXU_CSR = 3'd3;

    localparam issue_vec_t ISSUE_NONE  = 2'b00;
    localparam issue_vec_t ISSUE_FIRST = 2'b01;  // older instruction only
    localparam issue_vec_t ISSUE_BOTH  = 2'b11;

endpackage

`default_nettype wire

/* src/scoreboard.sv */
// in-flight write table of valid, destination and unit type per slot with two commit ports
`timescale 1ns/1ps
`default_nettype none

`include "hazard_defs.svh"

module scoreboard (
    input  wire logic                                  clk,
    input  wire logic                                  rst_n,
    input  wire issue_pkg::issue_vec_t                 issue_i,
    input  wire logic                                  inst1_rd_live_i,
    input  wire logic                                  inst2_rd_live_i,
    input  wire sb_pkg::commit_id_t                    inst1_id_i,
    input  wire sb_pkg::commit_id_t                    inst2_id_i,
    input  wire sb_pkg::reg_addr_t                     inst1_rd_i,
    input  wire sb_pkg::reg_addr_t                     inst2_rd_i,
    input  wire issue_pkg::exu_type_t                  inst1_exu_i,
    input  wire issue_pkg::exu_type_t                  inst2_exu_i,
    input  wire logic                                  commit_valid_i,
    input  wire sb_pkg::commit_id_t                    commit_id_i,
    input  wire logic                                  commit2_valid_i,
    input  wire sb_pkg::commit_id_t                    commit2_id_i,
    output sb_pkg::slot_vec_t                          valid_vec_o,
    output sb_pkg::slot_vec_t                          busy_vec_o,
    output sb_pkg::reg_addr_t [`SB_DEPTH-1:0]          sb_rd_o,
    output issue_pkg::exu_type_t [`SB_DEPTH-1:0]       sb_exu_o,
    output logic                                       atom_lock_o
);

    sb_pkg::slot_vec_t                    valid_q;
    sb_pkg::reg_addr_t [`SB_DEPTH-1:0]    rd_q;
    issue_pkg::exu_type_t [`SB_DEPTH-1:0] exu_q;
    sb_pkg::slot_vec_t                    commit_hit;  // slots retiring this cycle
    logic                                 wr1;
    logic                                 wr2;

    // only granted instructions with a real destination take a slot
    assign wr1 = issue_i[0] && inst1_rd_live_i;
    assign wr2 = issue_i[1] && inst2_rd_live_i;

    always_comb begin
        commit_hit = '0;
        if (commit_valid_i) commit_hit[commit_id_i] = 1'b1;
        if (commit2_valid_i) commit_hit[commit2_id_i] = 1'b1;
    end

    // set wins over clear since allocation never picks a slot that is still valid
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= '0;
        end else begin
            valid_q <= valid_q & ~commit_hit;
            if (wr1) valid_q[inst1_id_i] <= 1'b1;
            if (wr2) valid_q[inst2_id_i] <= 1'b1;
        end
    end

    // destination and unit type per slot
    always_ff @(posedge clk) begin
        if (wr1) begin
            rd_q[inst1_id_i]  <= inst1_rd_i;
            exu_q[inst1_id_i] <= inst1_exu_i;
        end
        if (wr2) begin
            rd_q[inst2_id_i]  <= inst2_rd_i;
            exu_q[inst2_id_i] <= inst2_exu_i;
        end
    end

    assign valid_vec_o = valid_q;                // still counts for allocation
    assign busy_vec_o  = valid_q & ~commit_hit;  // committing slots stop hazarding now
    assign sb_rd_o     = rd_q;
    assign sb_exu_o    = exu_q;
    assign atom_lock_o = |valid_q;               // any long write outstanding

endmodule

`default_nettype wire

/* src/slot_alloc.sv */
// commit ID allocation giving inst1 the lowest free slot and inst2 the next free one after it
`timescale 1ns/1ps
`default_nettype none

`include "hazard_defs.svh"

module slot_alloc (
    input  wire sb_pkg::slot_vec_t  valid_vec_i,
    input  wire logic               inst1_valid_i,
    input  wire logic               inst2_valid_i,
    output sb_pkg::commit_id_t      inst1_id_o,
    output sb_pkg::commit_id_t      inst2_id_o,
    output logic                    room_two_o
);

    sb_pkg::used_count_t used_cnt;
    sb_pkg::commit_id_t  first_free;
    sb_pkg::commit_id_t  id1;
    sb_pkg::commit_id_t  next_free;

    always_comb begin
        used_cnt = '0;
        for (int i = 0; i < `SB_DEPTH; i++) begin
            used_cnt = used_cnt + sb_pkg::used_count_t'(valid_vec_i[i]);
        end
    end

    assign room_two_o = (used_cnt <= sb_pkg::used_count_t'(`SB_MAX_USED_FOR_TWO));

    // scan downwards so the lowest free index is written last
    always_comb begin
        first_free = '0;
        for (int i = `SB_DEPTH - 1; i >= 0; i--) begin
            if (!valid_vec_i[i]) first_free = sb_pkg::commit_id_t'(i);
        end
    end

    assign id1 = inst1_valid_i ? first_free : '0;

    // circular search from one past id1 where the nearest hit wins
    always_comb begin
        sb_pkg::commit_id_t idx;
        next_free = '0;
        for (int k = `SB_DEPTH - 1; k >= 1; k--) begin
            idx = id1 + sb_pkg::commit_id_t'(k);  // wraps at depth
            if (!valid_vec_i[idx]) next_free = idx;
        end
    end

    assign inst1_id_o = id1;
    assign inst2_id_o = (inst2_valid_i && room_two_o) ? next_free : '0;

endmodule

`default_nettype wire

/* src/hazard_check.sv */
// RAW and WAW detection for both instructions against busy slots and between the pair
`timescale 1ns/1ps
`default_nettype none

`include "hazard_defs.svh"

module hazard_check (
    input  wire sb_pkg::slot_vec_t                     busy_vec_i,
    input  wire sb_pkg::reg_addr_t [`SB_DEPTH-1:0]     sb_rd_i,
    input  wire issue_pkg::exu_type_t [`SB_DEPTH-1:0]  sb_exu_i,
    input  wire logic                                  inst1_valid_i,
    input  wire sb_pkg::reg_addr_t                     inst1_rd_i,
    input  wire sb_pkg::reg_addr_t                     inst1_rs1_i,
    input  wire sb_pkg::reg_addr_t                     inst1_rs2_i,
    input  wire logic                                  inst1_rd_we_i,
    input  wire issue_pkg::exu_type_t                  inst1_exu_i,
    input  wire logic                                  inst2_valid_i,
    input  wire sb_pkg::reg_addr_t                     inst2_rd_i,
    input  wire sb_pkg::reg_addr_t                     inst2_rs1_i,
    input  wire sb_pkg::reg_addr_t                     inst2_rs2_i,
    input  wire logic                                  inst2_rd_we_i,
    input  wire issue_pkg::exu_type_t                  inst2_exu_i,
    output logic                                       haz1_sb_o,
    output logic                                       haz2_sb_o,
    output logic                                       haz2_on_1_o,
    output logic                                       inst1_rd_live_o,
    output logic                                       inst2_rd_live_o
);

    logic inst1_rs1_live;
    logic inst1_rs2_live;
    logic inst2_rs1_live;
    logic inst2_rs2_live;
    logic raw2_on_1;
    logic waw2_on_1;

    // one instruction against every busy slot
    function automatic logic sb_conflict(
        input sb_pkg::slot_vec_t                    busy,
        input sb_pkg::reg_addr_t [`SB_DEPTH-1:0]    rd_tab,
        input issue_pkg::exu_type_t [`SB_DEPTH-1:0] exu_tab,
        input logic                                 rs1_live,
        input sb_pkg::reg_addr_t                    rs1,
        input logic                                 rs2_live,
        input sb_pkg::reg_addr_t                    rs2,
        input logic                                 rd_live,
        input sb_pkg::reg_addr_t                    rd,
        input issue_pkg::exu_type_t                 exu
    );
        logic hit;
        hit = 1'b0;
        for (int i = 0; i < `SB_DEPTH; i++) begin
            if (busy[i]) begin
                if (rs1_live && (rs1 == rd_tab[i])) hit = 1'b1;
                if (rs2_live && (rs2 == rd_tab[i])) hit = 1'b1;
                // same unit writes back in order, so only a unit change is a WAW
                if (rd_live && (rd == rd_tab[i]) && (exu != exu_tab[i])) hit = 1'b1;
            end
        end
        return hit;
    endfunction

    // x0 reads and writes never hazard
    assign inst1_rs1_live  = inst1_valid_i && (inst1_rs1_i != '0);
    assign inst1_rs2_live  = inst1_valid_i && (inst1_rs2_i != '0);
    assign inst1_rd_live_o = inst1_valid_i && inst1_rd_we_i && (inst1_rd_i != '0);
    assign inst2_rs1_live  = inst2_valid_i && (inst2_rs1_i != '0);
    assign inst2_rs2_live  = inst2_valid_i && (inst2_rs2_i != '0);
    assign inst2_rd_live_o = inst2_valid_i && inst2_rd_we_i && (inst2_rd_i != '0);

    assign haz1_sb_o = sb_conflict(busy_vec_i, sb_rd_i, sb_exu_i,
                                   inst1_rs1_live, inst1_rs1_i,
                                   inst1_rs2_live, inst1_rs2_i,
                                   inst1_rd_live_o, inst1_rd_i, inst1_exu_i);

    assign haz2_sb_o = sb_conflict(busy_vec_i, sb_rd_i, sb_exu_i,
                                   inst2_rs1_live, inst2_rs1_i,
                                   inst2_rs2_live, inst2_rs2_i,
                                   inst2_rd_live_o, inst2_rd_i, inst2_exu_i);

    // inst2 against the older instruction of the same pair
    assign raw2_on_1 = inst1_rd_live_o &&
                       ((inst2_rs1_live && (inst2_rs1_i == inst1_rd_i)) ||
                        (inst2_rs2_live && (inst2_rs2_i == inst1_rd_i)));
    assign waw2_on_1 = inst1_rd_live_o && inst2_rd_live_o && (inst2_rd_i == inst1_rd_i);

    assign haz2_on_1_o = raw2_on_1 || waw2_on_1;

endmodule

`default_nettype wire

/* src/issue_ctrl.sv */
// issue decision from room, interrupt, hazards and jump/branch serialization in fixed priority
`timescale 1ns/1ps
`default_nettype none

`include "hazard_defs.svh"

module issue_ctrl (
    input  wire logic           room_two_i,
    input  wire logic           irq_req_i,
    input  wire logic           inst1_jump_i,
    input  wire logic           inst1_branch_i,
    input  wire logic           haz1_sb_i,
    input  wire logic           haz2_sb_i,
    input  wire logic           haz2_on_1_i,
    output issue_pkg::issue_vec_t issue_o
);

    always_comb begin
        if (!room_two_i) begin
            issue_o = issue_pkg::ISSUE_NONE;   // wait for a commit
        end else if (irq_req_i) begin
            issue_o = issue_pkg::ISSUE_NONE;
        end else if (haz1_sb_i) begin
            issue_o = issue_pkg::ISSUE_NONE;   // in order, so inst2 waits too
        end else if (inst1_jump_i || inst1_branch_i) begin
            issue_o = issue_pkg::ISSUE_FIRST;  // inst2 may be on the wrong path
        end else if (haz2_sb_i || haz2_on_1_i) begin
            issue_o = issue_pkg::ISSUE_FIRST;
        end else begin
            issue_o = issue_pkg::ISSUE_BOTH;
        end
    end

endmodule

`default_nettype wire

/* src/hazard_unit.sv */
// dual-issue hazard unit wiring scoreboard, ID allocation, hazard check and issue control
`timescale 1ns/1ps
`default_nettype none

`include "hazard_defs.svh"

module hazard_unit (
    input  wire logic                  clk,
    input  wire logic                  rst_n,
    input  wire logic                  inst1_valid_i,
    input  wire sb_pkg::reg_addr_t     inst1_rd_i,
    input  wire sb_pkg::reg_addr_t     inst1_rs1_i,
    input  wire sb_pkg::reg_addr_t     inst1_rs2_i,
    input  wire logic                  inst1_rd_we_i,
    input  wire issue_pkg::exu_type_t  inst1_exu_i,
    input  wire logic                  inst2_valid_i,
    input  wire sb_pkg::reg_addr_t     inst2_rd_i,
    input  wire sb_pkg::reg_addr_t     inst2_rs1_i,
    input  wire sb_pkg::reg_addr_t     inst2_rs2_i,
    input  wire logic                  inst2_rd_we_i,
    input  wire issue_pkg::exu_type_t  inst2_exu_i,
    input  wire logic                  commit_valid_i,
    input  wire sb_pkg::commit_id_t    commit_id_i,
    input  wire logic                  commit2_valid_i,
    input  wire sb_pkg::commit_id_t    commit2_id_i,
    input  wire logic                  inst1_jump_i,
    input  wire logic                  inst1_branch_i,
    input  wire logic                  irq_req_i,
    output issue_pkg::issue_vec_t      issue_o,
    output sb_pkg::commit_id_t         inst1_id_o,
    output sb_pkg::commit_id_t         inst2_id_o,
    output logic                       atom_lock_o
);

    sb_pkg::slot_vec_t                    valid_vec;
    sb_pkg::slot_vec_t                    busy_vec;
    sb_pkg::reg_addr_t [`SB_DEPTH-1:0]    sb_rd;
    issue_pkg::exu_type_t [`SB_DEPTH-1:0] sb_exu;
    logic                                 haz1_sb;
    logic                                 haz2_sb;
    logic                                 haz2_on_1;
    logic                                 inst1_rd_live;
    logic                                 inst2_rd_live;
    logic                                 room_two;

    scoreboard i_scoreboard (
        .clk             (clk),
        .rst_n           (rst_n),
        .issue_i         (issue_o),
        .inst1_rd_live_i (inst1_rd_live),
        .inst2_rd_live_i (inst2_rd_live),
        .inst1_id_i      (inst1_id_o),
        .inst2_id_i      (inst2_id_o),
        .inst1_rd_i      (inst1_rd_i),
        .inst2_rd_i      (inst2_rd_i),
        .inst1_exu_i     (inst1_exu_i),
        .inst2_exu_i     (inst2_exu_i),
        .commit_valid_i  (commit_valid_i),
        .commit_id_i     (commit_id_i),
        .commit2_valid_i (commit2_valid_i),
        .commit2_id_i    (commit2_id_i),
        .valid_vec_o     (valid_vec),
        .busy_vec_o      (busy_vec),
        .sb_rd_o         (sb_rd),
        .sb_exu_o        (sb_exu),
        .atom_lock_o     (atom_lock_o)
    );

    // IDs go out to the pipeline and back into the scoreboard
    slot_alloc i_slot_alloc (
        .valid_vec_i   (valid_vec),
        .inst1_valid_i (inst1_valid_i),
        .inst2_valid_i (inst2_valid_i),
        .inst1_id_o    (inst1_id_o),
        .inst2_id_o    (inst2_id_o),
        .room_two_o    (room_two)
    );

    hazard_check i_hazard_check (
        .busy_vec_i      (busy_vec),
        .sb_rd_i         (sb_rd),
        .sb_exu_i        (sb_exu),
        .inst1_valid_i   (inst1_valid_i),
        .inst1_rd_i      (inst1_rd_i),
        .inst1_rs1_i     (inst1_rs1_i),
        .inst1_rs2_i     (inst1_rs2_i),
        .inst1_rd_we_i   (inst1_rd_we_i),
        .inst1_exu_i     (inst1_exu_i),
        .inst2_valid_i   (inst2_valid_i),
        .inst2_rd_i      (inst2_rd_i),
        .inst2_rs1_i     (inst2_rs1_i),
        .inst2_rs2_i     (inst2_rs2_i),
        .inst2_rd_we_i   (inst2_rd_we_i),
        .inst2_exu_i     (inst2_exu_i),
        .haz1_sb_o       (haz1_sb),
        .haz2_sb_o       (haz2_sb),
        .haz2_on_1_o     (haz2_on_1),
        .inst1_rd_live_o (inst1_rd_live),
        .inst2_rd_live_o (inst2_rd_live)
    );

    issue_ctrl i_issue_ctrl (
        .room_two_i     (room_two),
        .irq_req_i      (irq_req_i),
        .inst1_jump_i   (inst1_jump_i),
        .inst1_branch_i (inst1_branch_i),
        .haz1_sb_i      (haz1_sb),
        .haz2_sb_i      (haz2_sb),
        .haz2_on_1_i    (haz2_on_1),
        .issue_o        (issue_o)
    );

endmodule

`default_nettype wire

/* bench/hazard_unit_asserts.sv */
// hazard unit checker for legal issue encoding, distinct commit IDs and atomic lock timing
`timescale 1ns/1ps
`default_nettype none

module hazard_unit_asserts (
    input  wire logic                   clk,
    input  wire logic                   rst_n,
    input  wire issue_pkg::issue_vec_t  issue_i,
    input  wire logic                   inst1_valid_i,
    input  wire logic                   inst2_valid_i,
    input  wire logic                   room_two_i,
    input  wire logic                   inst1_rd_live_i,
    input  wire sb_pkg::commit_id_t     inst1_id_i,
    input  wire sb_pkg::commit_id_t     inst2_id_i,
    input  wire logic                   atom_lock_i
);

    int fail_cnt = 0;  // failed assertions so far

    // in-order issue never grants inst2 alone
    issue_order: assert property (@(posedge clk) disable iff (!rst_n) issue_i != 2'b10)
        else begin
            fail_cnt++;
            $error("inst2 granted without inst1");
        end

    // two allocations in one cycle must land in different slots
    id_distinct: assert property (@(posedge clk) disable iff (!rst_n)
        (inst1_valid_i && inst2_valid_i && room_two_i) |-> (inst1_id_i != inst2_id_i))
        else begin
            fail_cnt++;
            $error("both instructions got commit ID %0d", inst1_id_i);
        end

    lock_after_reset: assert property (@(posedge clk) $rose(rst_n) |-> !atom_lock_i)
        else begin
            fail_cnt++;
            $error("atomic lock high right after reset release");
        end

    // a granted long write shows up in the lock one cycle later
    lock_after_issue: assert property (@(posedge clk) disable iff (!rst_n)
        (issue_i[0] && inst1_rd_live_i) |=> atom_lock_i)
        else begin
            fail_cnt++;
            $error("atomic lock low after a live inst1 write was issued");
        end

endmodule

bind hazard_unit hazard_unit_asserts i_hazard_unit_asserts (
    .clk             (clk),
    .rst_n           (rst_n),
    .issue_i         (issue_o),
    .inst1_valid_i   (inst1_valid_i),
    .inst2_valid_i   (inst2_valid_i),
    .room_two_i      (room_two),
    .inst1_rd_live_i (inst1_rd_live),
    .inst1_id_i      (inst1_id_o),
    .inst2_id_i      (inst2_id_o),
    .atom_lock_i     (atom_lock_o)
);

`default_nettype wire

/* bench/hazard_unit_tb.sv */
// testbench for the dual-issue hazard unit with a table of stimulus and expected outputs
`timescale 1ns/1ps
`default_nettype none

module hazard_unit_tb;

    localparam int CLK_PERIOD = 20;
    localparam int RST_CYCLES = 8;
    localparam int F          = -1;  // random filler register in x20..x31

    // one cycle of stimulus plus what the outputs must show mid-cycle
    typedef struct {
        int i1_valid;
        int i1_rd;
        int i1_rs1;
        int i1_rs2;
        int i1_we;
        int i1_exu;
        int i2_valid;
        int i2_rd;
        int i2_rs1;
        int i2_rs2;
        int i2_we;
        int i2_exu;
        int c1_valid;
        int c1_id;
        int c2_valid;
        int c2_id;
        int jump;
        int branch;
        int irq;
        int exp_issue;
        int exp_id1;
        int exp_id2;
        int exp_lock;
    } row_t;

    logic                  clk;
    logic                  rst_n;
    logic                  inst1_valid_i;
    sb_pkg::reg_addr_t     inst1_rd_i;
    sb_pkg::reg_addr_t     inst1_rs1_i;
    sb_pkg::reg_addr_t     inst1_rs2_i;
    logic                  inst1_rd_we_i;
    issue_pkg::exu_type_t  inst1_exu_i;
    logic                  inst2_valid_i;
    sb_pkg::reg_addr_t     inst2_rd_i;
    sb_pkg::reg_addr_t     inst2_rs1_i;
    sb_pkg::reg_addr_t     inst2_rs2_i;
    logic                  inst2_rd_we_i;
    issue_pkg::exu_type_t  inst2_exu_i;
    logic                  commit_valid_i;
    sb_pkg::commit_id_t    commit_id_i;
    logic                  commit2_valid_i;
    sb_pkg::commit_id_t    commit2_id_i;
    logic                  inst1_jump_i;
    logic                  inst1_branch_i;
    logic                  irq_req_i;
    issue_pkg::issue_vec_t issue_o;
    sb_pkg::commit_id_t    inst1_id_o;
    sb_pkg::commit_id_t    inst2_id_o;
    logic                  atom_lock_o;

    row_t rows[$];
    int   seed       = 25;
    int   row_idx    = 0;
    int   timeout_ns = 0;

    hazard_unit i_hazard_unit (.*);

    always #(CLK_PERIOD / 2) clk = ~clk;

    // destinations in the table stay below x20 so filler never hits one
    function automatic sb_pkg::reg_addr_t reg_or_filler(input int r);
        if (r >= 0) begin
            return sb_pkg::reg_addr_t'(r);
        end
        return sb_pkg::reg_addr_t'(20 + ({$random(seed)} % 12));
    endfunction

    task automatic add_row(input row_t r);
        rows.push_back(r);
    endtask

    // exu codes 0 alu, 1 mul, 2 div; issue 3 both, 1 inst1 only, 0 none
    task automatic load_rows();
        // v rd rs1 rs2 we exu (x2) | c1 id c2 id | jmp br irq | issue id1 id2 lock
        // reset, then independent pairs
        add_row('{1, 1, F, F, 1, 1, 1, 2, F, F, 1, 1, 0, 0, 0, 0, 0, 0, 0, 3, 0, 1, 0});
        add_row('{1, 3, F, F, 1, 1, 1, 4, F, F, 1, 2, 0, 0, 0, 0, 0, 0, 0, 3, 2, 3, 1});
        // RAW on the scoreboard
        add_row('{1, F, 1, F, 0, 0, 1, F, F, F, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 4, 5, 1});
        add_row('{1, F, F, F, 0, 0, 1, F, F, 3, 0, 0, 0, 0, 0, 0, 0, 0, 0, 1, 4, 5, 1});
        add_row('{1, F, 2, F, 0, 0, 1, F, F, F, 0, 0, 1, 1, 0, 0, 0, 0, 0, 3, 4, 5, 1});
        add_row('{1, F, 0, 0, 0, 0, 1, F, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 3, 1, 4, 1});
        // inst2 on inst1
        add_row('{1, 5, F, F, 1, 0, 1, F, 5, F, 0, 0, 0, 0, 0, 0, 0, 0, 0, 1, 1, 4, 1});
        add_row('{1, 6, F, F, 1, 0, 1, 6, F, F, 1, 0, 0, 0, 0, 0, 0, 0, 0, 1, 4, 5, 1});
        add_row('{1, 7, F, F, 0, 0, 1, F, 7, F, 0, 0, 1, 4, 1, 1, 0, 0, 0, 3, 5, 6, 1});
        add_row('{1, 0, F, F, 1, 0, 1, 0, 0, F, 1, 0, 0, 0, 0, 0, 0, 0, 0, 3, 1, 4, 1});
        // WAW where the unit type decides
        add_row('{1, 1, F, F, 1, 0, 1, F, F, F, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 1, 4, 1});
        add_row('{1, 1, F, F, 1, 1, 1, 4, F, F, 1, 2, 0, 0, 0, 0, 0, 0, 0, 3, 1, 4, 1});
        add_row('{1, F, F, F, 0, 0, 1, 3, F, F, 1, 0, 0, 0, 0, 0, 0, 0, 0, 1, 5, 6, 1});
        // interrupt, jump, branch
        add_row('{1, 8, F, F, 1, 0, 1, 9, F, F, 1, 0, 0, 0, 0, 0, 0, 0, 1, 0, 5, 6, 1});
        add_row('{1, 8, F, F, 1, 0, 1, 9, F, F, 1, 0, 0, 0, 0, 0, 1, 0, 0, 1, 5, 6, 1});
        add_row('{1, F, F, F, 0, 0, 1, F, F, F, 0, 0, 0, 0, 0, 0, 0, 1, 0, 1, 6, 7, 1});
        // fill to seven, then free two slots and reuse them
        add_row('{1, 10, F, F, 1, 0, 1, F, F, F, 0, 0, 0, 0, 0, 0, 0, 0, 0, 3, 6, 7, 1});
        add_row('{1, 12, F, F, 1, 0, 1, 13, F, F, 1, 0, 0, 0, 0, 0, 0, 0, 0, 0, 7, 0, 1});
        add_row('{1, 12, F, F, 1, 0, 1, 13, F, F, 1, 0, 1, 2, 1, 5, 0, 0, 0, 0, 7, 0, 1});
        add_row('{1, 12, F, F, 1, 0, 1, 13, F, F, 1, 0, 0, 0, 0, 0, 0, 0, 0, 3, 2, 5, 1});
        // drain everything and see the lock drop a cycle after the last commit
        add_row('{0, F, F, F, 0, 0, 0, F, F, F, 0, 0, 1, 0, 1, 1, 0, 0, 0, 0, 0, 0, 1});
        add_row('{0, F, F, F, 0, 0, 0, F, F, F, 0, 0, 1, 2, 1, 3, 0, 0, 0, 3, 0, 0, 1});
        add_row('{0, F, F, F, 0, 0, 0, F, F, F, 0, 0, 1, 4, 1, 5, 0, 0, 0, 3, 0, 0, 1});
        add_row('{0, F, F, F, 0, 0, 0, F, F, F, 0, 0, 1, 6, 0, 0, 0, 0, 0, 3, 0, 0, 1});
        add_row('{0, F, F, F, 0, 0, 0, F, F, F, 0, 0, 0, 0, 0, 0, 0, 0, 0, 3, 0, 0, 0});
        add_row('{1, F, 1, 4, 0, 0, 1, F, 12, 13, 0, 0, 0, 0, 0, 0, 0, 0, 0, 3, 0, 1, 0});
    endtask

    task automatic drive_row(input row_t r);
        inst1_valid_i   <= r.i1_valid[0];
        inst1_rd_i      <= reg_or_filler(r.i1_rd);
        inst1_rs1_i     <= reg_or_filler(r.i1_rs1);
        inst1_rs2_i     <= reg_or_filler(r.i1_rs2);
        inst1_rd_we_i   <= r.i1_we[0];
        inst1_exu_i     <= issue_pkg::exu_type_t'(r.i1_exu);
        inst2_valid_i   <= r.i2_valid[0];
        inst2_rd_i      <= reg_or_filler(r.i2_rd);
        inst2_rs1_i     <= reg_or_filler(r.i2_rs1);
        inst2_rs2_i     <= reg_or_filler(r.i2_rs2);
        inst2_rd_we_i   <= r.i2_we[0];
        inst2_exu_i     <= issue_pkg::exu_type_t'(r.i2_exu);
        commit_valid_i  <= r.c1_valid[0];
        commit_id_i     <= sb_pkg::commit_id_t'(r.c1_id);
        commit2_valid_i <= r.c2_valid[0];
        commit2_id_i    <= sb_pkg::commit_id_t'(r.c2_id);
        inst1_jump_i    <= r.jump[0];
        inst1_branch_i  <= r.branch[0];
        irq_req_i       <= r.irq[0];
    endtask

    task automatic check_val(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
        if (actual !== expected) begin
            $display("ERROR %s: got 0x%0h, expected 0x%0h (row %0d)",
                     name, actual, expected, row_idx);
            $display("tests failed");
            $fatal(1, "output mismatch");
        end
    endtask

    initial begin : stimulus
        clk             = 1'b0;
        rst_n           = 1'b0;
        inst1_valid_i   = 1'b0;
        inst1_rd_i      = '0;
        inst1_rs1_i     = '0;
        inst1_rs2_i     = '0;
        inst1_rd_we_i   = 1'b0;
        inst1_exu_i     = '0;
        inst2_valid_i   = 1'b0;
        inst2_rd_i      = '0;
        inst2_rs1_i     = '0;
        inst2_rs2_i     = '0;
        inst2_rd_we_i   = 1'b0;
        inst2_exu_i     = '0;
        commit_valid_i  = 1'b0;
        commit_id_i     = '0;
        commit2_valid_i = 1'b0;
        commit2_id_i    = '0;
        inst1_jump_i    = 1'b0;
        inst1_branch_i  = 1'b0;
        irq_req_i       = 1'b0;
        load_rows();
        timeout_ns = (rows.size() + RST_CYCLES) * 2 * CLK_PERIOD;

        repeat (RST_CYCLES) @(posedge clk);
        rst_n <= 1'b1;  // first row goes out on the release edge
        for (int i = 0; i < rows.size(); i++) begin
            row_idx = i;
            drive_row(rows[i]);
            @(negedge clk);  // combinational outputs settled
            check_val("issue_o", issue_o, rows[i].exp_issue);
            check_val("inst1_id_o", inst1_id_o, rows[i].exp_id1);
            check_val("inst2_id_o", inst2_id_o, rows[i].exp_id2);
            check_val("atom_lock_o", atom_lock_o, rows[i].exp_lock);
            @(posedge clk);
        end

        if (i_hazard_unit.i_hazard_unit_asserts.fail_cnt != 0) begin
            $display("assertion failures reported by the bound checker: %0d",
                     i_hazard_unit.i_hazard_unit_asserts.fail_cnt);
            $display("tests failed");
            $fatal(1, "assertion failures");
        end else begin
            $display("all tests passed");
            $finish;
        end
    end

    // twice the expected run time
    initial begin : watchdog
        wait (timeout_ns > 0);
        #(timeout_ns);
        $display("timeout: the stimulus table did not finish within %0d ns", timeout_ns);
        $display("tests failed");
        $fatal(1, "watchdog expired");
    end

endmodule

`default_nettype wire

/* hazard_unit.f */
+incdir+src
src/sb_pkg.sv
src/issue_pkg.sv
src/scoreboard.sv
src/slot_alloc.sv
src/hazard_check.sv
src/issue_ctrl.sv
src/hazard_unit.sv
bench/hazard_unit_asserts.sv
bench/hazard_unit_tb.sv

/* Bender.yml */
package:
  name: hazard_unit

sources:
  # synthesizable design
  - include_dirs:
      - src
    files:
      - src/sb_pkg.sv
      - src/issue_pkg.sv
      - src/scoreboard.sv
      - src/slot_alloc.sv
      - src/hazard_check.sv
      - src/issue_ctrl.sv
      - src/hazard_unit.sv

  # simulation only
  - target: test
    include_dirs:
      - src
    files:
      - bench/hazard_unit_asserts.sv
      - bench/hazard_unit_tb.sv
